//--- logic/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// data bits carried in one frame
`define UART_DATA_BITS 8

// parity sense, 0 gives even parity and 1 gives odd parity
`define UART_PARITY_ODD 0

// tx_clk cycles spent on every bit of the frame
`define UART_CLKS_PER_BIT 8

// flops in front of the receiver for the asynchronous line
`define UART_SYNC_STAGES 3

// start + data + parity + stop
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + 1 + 1)

`endif

//--- logic/uart_pkg.sv
`include "uart_cfg.svh"

package uart_pkg;

	typedef logic [`UART_DATA_BITS-1:0] data_t; // one data word

	// index of a bit inside the frame, 0 is the start bit
	typedef logic [$clog2(`UART_FRAME_BITS + 1)-1:0] bit_cnt_t;

	// cycle position inside one bit period
	typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] clk_cnt_t;

	typedef enum logic {
		TX_IDLE, // line held high, waiting for enable
		TX_SEND  // shifting the frame out
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,   // watching for a falling edge
		RX_START,  // counting to the middle of the start bit
		RX_DATA,   // sampling data bits
		RX_PARITY, // sampling the parity bit
		RX_STOP    // sampling the stop bit
	} rx_state_e;

	typedef struct packed {
		data_t data;  // last received word
		logic  valid; // one-cycle pulse per frame
		logic  error; // parity mismatch or stop bit low
	} rx_result_t;

endpackage

//--- logic/uart_tx.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx (
	input  logic            tx_clk,
	input  logic            reset_tx,
	input  logic            i_enable,
	input  uart_pkg::data_t i_data,
	output logic            o_busy,
	output logic            o_serial
);
	import uart_pkg::*;

	localparam int FRAME_W = `UART_FRAME_BITS;

	localparam clk_cnt_t CLK_LAST = clk_cnt_t'(`UART_CLKS_PER_BIT - 1); // last cycle of a bit
	localparam bit_cnt_t BIT_LAST = bit_cnt_t'(`UART_FRAME_BITS - 1);   // stop bit index

	tx_state_e          state_q;   // transmitter FSM
	logic [FRAME_W-1:0] frame_q;   // frame shift register, bit 0 is on the line
	clk_cnt_t           clk_cnt_q; // cycles spent in the current bit
	bit_cnt_t           bit_cnt_q; // bit being sent

	logic               parity;    // parity of the incoming word
	logic               accept;    // enable taken this cycle
	logic               bit_end;   // last cycle of the current bit
	logic               frame_end; // last cycle of the stop bit

	// xor of the data gives even parity, flip it for odd
	assign parity = (^i_data) ^ (`UART_PARITY_ODD != 0);

	assign accept    = i_enable && (state_q == TX_IDLE); // enable during busy is dropped
	assign bit_end   = (clk_cnt_q == CLK_LAST);
	assign frame_end = bit_end && (bit_cnt_q == BIT_LAST);

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q   <= TX_IDLE;
			frame_q   <= '1;              // idle line is high
			clk_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else begin
			case (state_q)
				TX_IDLE: begin
					if (accept) begin
						// stop, parity, data lsb first, start
						frame_q   <= {1'b1, parity, i_data, 1'b0};
						clk_cnt_q <= '0;
						bit_cnt_q <= '0;
						state_q   <= TX_SEND; // start bit goes out next cycle
					end
				end

				TX_SEND: begin
					if (bit_end) begin
						clk_cnt_q <= '0;
						frame_q   <= {1'b1, frame_q[FRAME_W-1:1]}; // back-fill with idle level
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
					if (frame_end) begin
						state_q <= TX_IDLE; // busy drops, next enable may follow at once
					end
				end

				default: begin
					state_q <= TX_IDLE;
				end
			endcase
		end
	end

	assign o_busy   = (state_q == TX_SEND); // high for FRAME_BITS * CLKS_PER_BIT cycles
	assign o_serial = frame_q[0];            // all ones once the stop bit has left

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx (
	input  logic                 tx_clk,
	input  logic                 reset_tx,
	input  logic                 i_line,
	output uart_pkg::rx_result_t o_result
);
	import uart_pkg::*;

	localparam int SYNC_W = `UART_SYNC_STAGES;
	localparam int DATA_W = `UART_DATA_BITS;

	localparam clk_cnt_t CLK_HALF  = clk_cnt_t'(`UART_CLKS_PER_BIT / 2); // middle of a bit
	localparam clk_cnt_t CLK_LAST  = clk_cnt_t'(`UART_CLKS_PER_BIT - 1); // one period on
	localparam bit_cnt_t DATA_LAST = bit_cnt_t'(`UART_DATA_BITS - 1);

	logic [SYNC_W-1:0] sync_q;    // synchronizer chain, msb is the safe copy
	logic              line_s;    // synchronized line
	logic              prev_q;    // line_s one cycle back
	logic              fall;      // high to low seen after the synchronizer

	rx_state_e         state_q;   // receiver FSM
	clk_cnt_t          clk_cnt_q; // cycles since the last sample point
	bit_cnt_t          bit_cnt_q; // data bits taken so far
	logic              sample;    // sample point in data, parity and stop

	data_t             shift_q;   // data assembled lsb first
	logic              par_q;     // running xor of the data bits
	logic              par_err_q; // parity bit disagreed
	rx_result_t        result_q;  // registered result

	assign line_s = sync_q[SYNC_W-1];
	assign fall   = prev_q && !line_s;
	assign sample = (clk_cnt_q == CLK_LAST);

	// line comes from outside the clock domain when loopback is off
	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1; // idle level, no false start after reset
			prev_q <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_W-2:0], i_line};
			prev_q <= line_s;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q   <= RX_IDLE;
			clk_cnt_q <= '0;
			bit_cnt_q <= '0;
			result_q  <= '0;
		end else begin
			result_q.valid <= 1'b0; // pulse only, data and error hold
			case (state_q)
				RX_IDLE: begin
					if (fall) begin
						clk_cnt_q <= clk_cnt_t'(1); // edge cycle counts as the first one
						state_q   <= RX_START;
					end
				end

				RX_START: begin
					if (clk_cnt_q == CLK_HALF) begin
						clk_cnt_q <= '0;
						bit_cnt_q <= '0;
						// glitch if the line is already back high
						state_q   <= line_s ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end

				RX_DATA: begin
					if (sample) begin
						clk_cnt_q <= '0;
						bit_cnt_q <= bit_cnt_q + 1'b1;
						if (bit_cnt_q == DATA_LAST) begin
							state_q <= RX_PARITY;
						end
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end

				RX_PARITY: begin
					if (sample) begin
						clk_cnt_q <= '0;
						state_q   <= RX_STOP;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end

				RX_STOP: begin
					if (sample) begin
						clk_cnt_q      <= '0;
						result_q.valid <= 1'b1;
						result_q.data  <= shift_q;
						result_q.error <= par_err_q || !line_s; // stop must be high
						// a low stop leaves prev_q low, no edge until the line idles
						state_q        <= RX_IDLE;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end

				default: begin
					state_q <= RX_IDLE;
				end
			endcase
		end
	end

	// data path, only meaningful between start check and stop sample
	always_ff @(posedge tx_clk) begin
		if (state_q == RX_START) begin
			par_q <= 1'b0; // fresh parity per frame
		end
		if ((state_q == RX_DATA) && sample) begin
			shift_q <= {line_s, shift_q[DATA_W-1:1]}; // lsb arrives first
			par_q   <= par_q ^ line_s;
		end
		if ((state_q == RX_PARITY) && sample) begin
			par_err_q <= par_q ^ line_s ^ (`UART_PARITY_ODD != 0);
		end
	end

	assign o_result = result_q;

endmodule

//--- logic/uart_loopback.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_loopback (
	input  logic                 tx_clk,
	input  logic                 reset_tx,
	input  logic                 i_enable,
	input  uart_pkg::data_t      i_data,
	input  logic                 i_loopback, // level, 1 feeds the tx line back to rx
	input  logic                 i_serial,   // external line, idles high
	output logic                 o_busy,
	output logic                 o_serial,
	output uart_pkg::rx_result_t o_rx
);

	logic tx_line; // transmitter output
	logic rx_line; // what the receiver listens to

	uart_tx tx_i (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_enable (i_enable),
		.i_data   (i_data),
		.o_busy   (o_busy),
		.o_serial (tx_line)
	);

	// own line in loopback, outside line otherwise
	assign rx_line  = i_loopback ? tx_line : i_serial;
	assign o_serial = tx_line;

	uart_rx rx_i (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_line   (rx_line),  // synchronized inside the receiver
		.o_result (o_rx)
	);

endmodule

//--- verif/uart_chk.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_chk (
	input logic                 tx_clk,
	input logic                 reset_tx,
	input logic                 i_busy,
	input logic                 i_serial,
	input uart_pkg::rx_result_t i_rx
);
	import uart_pkg::*;

	localparam int BUSY_CYCLES = `UART_FRAME_BITS * `UART_CLKS_PER_BIT;

	int busy_cnt; // cycles of busy seen in the current period

	always_ff @(posedge tx_clk) begin
		if (reset_tx || !i_busy) begin
			busy_cnt <= 0;
		end else begin
			busy_cnt <= busy_cnt + 1;
		end
	end

	// valid is a single-cycle pulse
	assert property (@(posedge tx_clk) disable iff (reset_tx) i_rx.valid |=> !i_rx.valid)
		else $error("receive valid high on two cycles in a row");

	// idle line stays high
	assert property (@(posedge tx_clk) disable iff (reset_tx) !i_busy |-> i_serial)
		else $error("serial line low while transmitter idle");

	assert property (@(posedge tx_clk) disable iff (reset_tx) i_busy |-> (busy_cnt < BUSY_CYCLES))
		else $error("busy held longer than one frame");

	assert property (@(posedge tx_clk) disable iff (reset_tx) $fell(i_busy) |-> (busy_cnt == BUSY_CYCLES))
		else $error("busy period shorter than one frame");

endmodule

bind uart_loopback uart_chk chk_i (
	.tx_clk   (tx_clk),
	.reset_tx (reset_tx),
	.i_busy   (o_busy),
	.i_serial (o_serial),
	.i_rx     (o_rx)
);

//--- verif/uart_tb.sv
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tb;
	import uart_pkg::*;

	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int FRAME_BITS   = `UART_FRAME_BITS;
	localparam int BUSY_CYCLES  = `UART_FRAME_BITS * `UART_CLKS_PER_BIT; // 88 with the defaults
	localparam int TEST_BUDGET  = 2 * BUSY_CYCLES + 64;                   // cycles allowed per test
	localparam int MAX_GAP      = 24;                                     // random idle between tests

	logic       tx_clk;
	logic       reset_tx;
	logic       i_enable;
	data_t      i_data;
	logic       i_loopback;
	logic       i_serial;
	logic       o_busy;
	logic       o_serial;
	rx_result_t o_rx;

	// one entry per line of the tests file
	string t_name[$];
	string t_mode[$];       // L loopback, S external line
	data_t t_data[$];
	int    t_par_fault[$];
	int    t_stop_fault[$];
	int    t_busy_ctl[$];   // 0 plain, 1 enable during busy, 2 back-to-back
	data_t t_exp_data[$];
	int    t_exp_err[$];

	int         cycle_cnt;    // cycles since time zero
	int         cycle_limit;  // run ends here
	int         errors;
	int         test_fails;   // failed checks of the running test
	int         tests_run;
	int         tests_failed;
	int         valid_cnt;    // valid pulses seen so far
	int         busy_run;     // length of the busy period in progress
	int         busy_len;     // length of the last finished busy period
	logic       busy_now;     // o_busy at the latest sample
	logic       busy_before;  // o_busy one sample earlier
	logic       got_valid;
	rx_result_t got;          // latest result with valid set

	uart_loopback dut_i (
		.tx_clk     (tx_clk),
		.reset_tx   (reset_tx),
		.i_enable   (i_enable),
		.i_data     (i_data),
		.i_loopback (i_loopback),
		.i_serial   (i_serial),
		.o_busy     (o_busy),
		.o_serial   (o_serial),
		.o_rx       (o_rx)
	);

	initial begin
		tx_clk = 1'b0;
		forever begin
			#2 tx_clk = ~tx_clk; // 4 ns period
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$finish;
	endtask

	// limit is known once the tests file has been read
	initial begin
		cycle_cnt = 0;
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge tx_clk);
			cycle_cnt++;
		end
		abort_run($sformatf("timeout: no progress after %0d cycles", cycle_cnt));
	end

	// one clock, sampled 1 ns after the edge where outputs have settled
	task automatic step();
		@(posedge tx_clk);
		#1;
		busy_before = busy_now;
		busy_now    = o_busy;
		if (o_rx.valid) begin
			valid_cnt++;
			got_valid = 1'b1;
			got       = o_rx;
		end
		if (busy_now) begin
			busy_run++;
		end else if (busy_before) begin
			busy_len = busy_run; // period just ended
			busy_run = 0;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) step();
	endtask

	task automatic wait_valid();
		while (!got_valid) begin
			step(); // bounded by the cycle limit
		end
	endtask

	task automatic check_value(input string name, input string field,
			input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else begin
			$display("mismatch %s %s: expected 0x%0h, actual 0x%0h", name, field, exp, act);
			test_fails++;
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		assert (cond) else begin
			$display("%s: %s", name, what);
			test_fails++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_fails;
		if (test_fails != 0) begin
			tests_failed++;
		end
		$display("test %s: %s", name, (test_fails == 0) ? "pass" : "FAIL");
	endtask

	task automatic load_tests(output string err);
		int    fd;
		int    code;
		string name;
		string mode;
		string rest;
		data_t data;
		int    pf;
		int    sf;
		int    bc;
		data_t ed;
		int    ee;
		err = "";
		fd  = $fopen("verif/uart_tests.txt", "r");
		if (fd == 0) begin
			err = "cannot open verif/uart_tests.txt";
		end else begin
			while (!$feof(fd) && (err == "")) begin
				code = $fscanf(fd, "%s", name);
				if (code != 1) begin
					break; // end of file
				end
				if (name.substr(0, 0) == "#") begin
					code = $fgets(rest, fd); // skip the comment line
				end else begin
					code = $fscanf(fd, " %s %h %d %d %d %h %d", mode, data, pf, sf, bc, ed, ee);
					if (code != 7) begin
						err = $sformatf("bad line in tests file at %s", name);
					end else begin
						t_name.push_back(name);
						t_mode.push_back(mode);
						t_data.push_back(data);
						t_par_fault.push_back(pf);
						t_stop_fault.push_back(sf);
						t_busy_ctl.push_back(bc);
						t_exp_data.push_back(ed);
						t_exp_err.push_back(ee);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// frame built here from the framing rules, faults on request
	task automatic send_serial(input data_t data, input logic bad_par, input logic low_stop);
		logic [FRAME_BITS-1:0] frame;
		logic                  parity;
		parity = ^data; // even parity
		if (`UART_PARITY_ODD != 0) begin
			parity = ~parity;
		end
		if (bad_par) begin
			parity = ~parity;
		end
		frame = {~low_stop, parity, data, 1'b0}; // stop, parity, data, start
		for (int b = 0; b < FRAME_BITS; b++) begin
			i_serial = frame[b]; // lsb first
			wait_cycles(CLKS_PER_BIT);
		end
		i_serial = 1'b1; // back to idle
	endtask

	task automatic send_loopback(input int idx);
		i_enable = 1'b1;
		i_data   = t_data[idx];
		step();
		i_enable = 1'b0;
		check_true(t_name[idx], busy_now, "busy did not rise on the cycle after enable");
		if (t_busy_ctl[idx] == 1) begin
			wait_cycles(3 * CLKS_PER_BIT); // well inside the frame
			i_enable = 1'b1;
			i_data   = ~t_data[idx];       // must not reach the receiver
			step();
			i_enable = 1'b0;
		end
	endtask

	task automatic run_test(input int idx);
		test_fails = 0;
		got_valid  = 1'b0;
		// one result per earlier frame, nothing extra since the last one
		check_value(t_name[idx], "results before frame", idx, valid_cnt);
		if (t_mode[idx] == "S") begin
			i_loopback = 1'b0;
			send_serial(t_data[idx], t_par_fault[idx] != 0, t_stop_fault[idx] != 0);
		end else begin
			i_loopback = 1'b1;
			if (t_busy_ctl[idx] == 2) begin
				check_true(t_name[idx], !busy_now && busy_before,
					"enable could not be issued on the cycle busy fell");
			end
			while (busy_now) begin
				step();
			end
			busy_len = -1; // filled in when this frame ends
			send_loopback(idx);
		end
		wait_valid();
		check_value(t_name[idx], "data", 32'(t_exp_data[idx]), 32'(got.data));
		check_value(t_name[idx], "error", t_exp_err[idx], 32'(got.error));
		if (t_mode[idx] != "S") begin
			while (busy_now) begin
				step();
			end
			check_value(t_name[idx], "busy cycles", BUSY_CYCLES, busy_len);
		end
		finish_test(t_name[idx]);
	endtask

	initial begin
		int    gap;
		string load_err;
		void'($urandom(32'hf20e_495d)); // seeded once, gaps only
		reset_tx     = 1'b1;
		i_enable     = 1'b0;
		i_data       = '0;
		i_loopback   = 1'b1;
		i_serial     = 1'b1;
		errors       = 0;
		test_fails   = 0;
		tests_run    = 0;
		tests_failed = 0;
		valid_cnt    = 0;
		busy_run     = 0;
		busy_len     = -1;
		busy_now     = 1'b0;
		busy_before  = 1'b0;
		got_valid    = 1'b0;
		got          = '0;
		load_tests(load_err);
		if (load_err != "") begin
			abort_run(load_err);
		end else begin
			cycle_limit = t_name.size() * TEST_BUDGET;
			wait_cycles(4); // reset held for 4 edges
			reset_tx = 1'b0;

			test_fails = 0;
			check_value("reset", "busy", 0, 32'(o_busy));
			check_value("reset", "serial", 1, 32'(o_serial));
			check_value("reset", "valid", 0, 32'(o_rx.valid));
			check_value("reset", "error", 0, 32'(o_rx.error));
			check_value("reset", "data", 0, 32'(o_rx.data));
			finish_test("reset");

			for (int i = 0; i < t_name.size(); i++) begin
				if (t_busy_ctl[i] != 2) begin
					gap = 2 + int'($urandom_range(MAX_GAP));
					wait_cycles(gap);
				end
				run_test(i);
			end
			wait_cycles(BUSY_CYCLES); // room for a stray frame to show up
			assert (valid_cnt == t_name.size()) else begin
				$display("receiver gave %0d results for %0d frames", valid_cnt, t_name.size());
				errors++;
			end
			$display("tests run %0d, passed %0d, failed %0d, errors %0d",
				tests_run, tests_run - tests_failed, tests_failed, errors);
			if (errors == 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

//--- verif/uart_tests.txt
# name mode data par_fault stop_fault busy exp_data exp_err
# mode L goes through the transmitter in loopback, S drives the external line
# busy 1 pulses enable with other data mid-frame, 2 starts on the cycle busy falls
lb_zeros       L 00 0 0 0 00 0
lb_ones        L ff 0 0 0 ff 0
lb_a5          L a5 0 0 0 a5 0
lb_5a_b2b      L 5a 0 0 2 5a 0
lb_01          L 01 0 0 0 01 0
lb_80_b2b      L 80 0 0 2 80 0
lb_3c_b2b      L 3c 0 0 2 3c 0
lb_ignore_c3   L c3 0 0 1 c3 0
lb_after_ign   L 7e 0 0 2 7e 0
lb_ignore_0f   L 0f 0 0 1 0f 0
ser_good_96    S 96 0 0 0 96 0
ser_par_96     S 96 1 0 0 96 1
ser_par_ff     S ff 1 0 0 ff 1
ser_par_00     S 00 1 0 0 00 1
ser_stop_0f    S 0f 0 1 0 0f 1
ser_stop_ff    S ff 0 1 0 ff 1
ser_both_41    S 41 1 1 0 41 1
ser_good_00    S 00 0 0 0 00 0
ser_good_ff    S ff 0 0 0 ff 0
lb_back_e7     L e7 0 0 0 e7 0
lb_e7_b2b      L 18 0 0 2 18 0
lb_55          L 55 0 0 0 55 0
ser_good_6d    S 6d 0 0 0 6d 0
lb_end_aa      L aa 0 0 0 aa 0

//--- project.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_loopback.sv
verif/uart_chk.sv
verif/uart_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
